//--- logic/io_hub_pkg.sv
// shared definitions for the legacy I/O hub.
// bus widths, the device window table, the unmapped read value
// and the CPU I/O operation enum.

package io_hub_pkg;

    // CPU I/O address and data widths.
    localparam int IO_ADDR_W = 16;
    localparam int IO_DATA_W = 8;

    // register offset inside a device window, four registers each.
    localparam int SLOT_OFS_W = 2;

    // number of entries in the window table.
    localparam int MAX_SLOTS = 6;

    // window base addresses, each aligned to four.
    // entry k serves slot k, so a smaller NUM_SLOTS drops the tail.
    localparam logic [IO_ADDR_W-1:0] SLOT_BASE [MAX_SLOTS] = '{
        16'h0020,   // interrupt controller master
        16'h0040,   // interval timer
        16'h0060,   // keyboard
        16'h0070,   // real-time clock
        16'h00A0,   // interrupt controller slave
        16'h03C0    // video
    };

    // an empty PC bus floats high.
    localparam logic [IO_DATA_W-1:0] UNMAPPED_DATA = 8'hFF;

    // CPU operation seen in one cycle.
    typedef enum logic [1:0] {
        IO_IDLE    = 2'b00,
        IO_READ    = 2'b01,
        IO_WRITE   = 2'b10,
        IO_ILLEGAL = 2'b11
    } io_op_e;

endpackage

//--- logic/io_port_decoder.sv
// io_port_decoder: classifies the CPU strobes and matches the port
// address against the device window table. produces one-hot slot
// selects, the register offset and an unmapped-read flag.

`timescale 1ns/1ns

module io_port_decoder #(
    parameter int NUM_SLOTS = io_hub_pkg::MAX_SLOTS
) (
    input  logic                              clk_sys,
    input  logic [io_hub_pkg::IO_ADDR_W-1:0]  i_io_address,
    input  logic                              i_io_read,
    input  logic                              i_io_write,
    input  logic [io_hub_pkg::IO_DATA_W-1:0]  i_io_writedata,
    output logic [NUM_SLOTS-1:0]              o_slot_rd_sel,
    output logic [NUM_SLOTS-1:0]              o_slot_wr_sel,
    output logic [io_hub_pkg::SLOT_OFS_W-1:0] o_reg_ofs,
    output logic [io_hub_pkg::IO_DATA_W-1:0]  o_wr_data,
    output logic                              o_unmapped_rd
);

    localparam int ADDR_W = io_hub_pkg::IO_ADDR_W;
    localparam int OFS_W  = io_hub_pkg::SLOT_OFS_W;

    io_hub_pkg::io_op_e   io_op;
    logic [NUM_SLOTS-1:0] hit;
    logic                 op_read;
    logic                 op_write;

    // strobe classification.
    always_comb begin
        case ({i_io_write, i_io_read})
            2'b01:   io_op = io_hub_pkg::IO_READ;
            2'b10:   io_op = io_hub_pkg::IO_WRITE;
            2'b11:   io_op = io_hub_pkg::IO_ILLEGAL;
            default: io_op = io_hub_pkg::IO_IDLE;
        endcase
    end

    // an illegal cycle selects nothing.
    assign op_read  = (io_op == io_hub_pkg::IO_READ);
    assign op_write = (io_op == io_hub_pkg::IO_WRITE);

    // window match on the address above the register offset.
    for (genvar k = 0; k < NUM_SLOTS; k++) begin : g_hit
        assign hit[k] = (i_io_address[ADDR_W-1:OFS_W] ==
                         io_hub_pkg::SLOT_BASE[k][ADDR_W-1:OFS_W]);
    end

    assign o_slot_rd_sel = hit & {NUM_SLOTS{op_read}};
    assign o_slot_wr_sel = hit & {NUM_SLOTS{op_write}};

    // offset and data are shared by all slots, the selects pick one.
    assign o_reg_ofs = i_io_address[OFS_W-1:0];
    assign o_wr_data = i_io_writedata;

    // reads that miss every window are answered by the merge.
    // unmapped writes simply select nothing.
    assign o_unmapped_rd = op_read && (hit == '0);

    // the CPU issues one operation per cycle.
    a_no_illegal_op: assert property (
        @(posedge clk_sys) io_op != io_hub_pkg::IO_ILLEGAL
    ) else $error("read and write strobes high in the same cycle");

    // windows in the table must not overlap.
    a_hit_onehot: assert property (
        @(posedge clk_sys) $onehot0(hit)
    ) else $error("port 0x%h hits more than one window", i_io_address);

endmodule

//--- logic/io_reg_slot.sv
// io_reg_slot: one device window of four byte registers.
// writes land at the strobe edge, reads return registered data
// with a one-cycle valid.

`timescale 1ns/1ns

module io_reg_slot (
    input  logic                              clk_sys,
    input  logic                              i_rst_n,
    input  logic                              i_rd_sel,
    input  logic                              i_wr_sel,
    input  logic [io_hub_pkg::SLOT_OFS_W-1:0] i_reg_ofs,
    input  logic [io_hub_pkg::IO_DATA_W-1:0]  i_wr_data,
    output logic [io_hub_pkg::IO_DATA_W-1:0]  o_rd_data,
    output logic                              o_rd_valid
);

    localparam int NUM_REGS = 1 << io_hub_pkg::SLOT_OFS_W;

    logic [io_hub_pkg::IO_DATA_W-1:0] regs [NUM_REGS];

    // register file, cleared at reset as the device state would be.
    always_ff @(posedge clk_sys) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_sel) begin
            regs[i_reg_ofs] <= i_wr_data;
        end
    end

    // read return.
    // data falls back to zero when idle so the merge can OR all slots.
    always_ff @(posedge clk_sys) begin
        if (!i_rst_n) begin
            o_rd_data  <= '0;
            o_rd_valid <= 1'b0;
        end else begin
            o_rd_valid <= i_rd_sel;
            if (i_rd_sel) begin
                o_rd_data <= regs[i_reg_ofs];
            end else begin
                o_rd_data <= '0;
            end
        end
    end

    // the decoder never selects a slot for both directions at once.
    a_no_rd_wr_overlap: assert property (
        @(posedge clk_sys) disable iff (!i_rst_n)
        !(i_rd_sel && i_wr_sel)
    ) else $error("slot read- and write-selected in the same cycle");

endmodule

//--- logic/io_read_merge.sv
// io_read_merge: collects slot read returns and unmapped reads into
// the registered CPU read data and valid pair.

`timescale 1ns/1ns

module io_read_merge #(
    parameter int NUM_SLOTS = io_hub_pkg::MAX_SLOTS
) (
    input  logic                                       clk_sys,
    input  logic                                       i_rst_n,
    input  logic [NUM_SLOTS*io_hub_pkg::IO_DATA_W-1:0] i_slot_rd_data,
    input  logic [NUM_SLOTS-1:0]                       i_slot_rd_valid,
    input  logic                                       i_unmapped_rd,
    output logic [io_hub_pkg::IO_DATA_W-1:0]           o_io_readdata,
    output logic                                       o_io_readdatavalid
);

    localparam int DATA_W = io_hub_pkg::IO_DATA_W;

    logic              unmapped_q;
    logic [DATA_W-1:0] slot_data_or;
    logic              any_valid;

    // the slots take one cycle to answer, so the miss waits one too.
    always_ff @(posedge clk_sys) begin
        if (!i_rst_n) begin
            unmapped_q <= 1'b0;
        end else begin
            unmapped_q <= i_unmapped_rd;
        end
    end

    // idle slots return zero, so an OR picks the active one.
    always_comb begin
        slot_data_or = '0;
        for (int k = 0; k < NUM_SLOTS; k++) begin
            slot_data_or = slot_data_or | i_slot_rd_data[k*DATA_W +: DATA_W];
        end
    end

    assign any_valid = (|i_slot_rd_valid) || unmapped_q;

    // output stage toward the CPU.
    always_ff @(posedge clk_sys) begin
        if (!i_rst_n) begin
            o_io_readdata      <= '0;
            o_io_readdatavalid <= 1'b0;
        end else begin
            o_io_readdatavalid <= any_valid;
            if (unmapped_q) begin
                o_io_readdata <= io_hub_pkg::UNMAPPED_DATA;
            end else begin
                o_io_readdata <= slot_data_or;
            end
        end
    end

    // one read per cycle upstream means one answer per cycle here.
    a_single_source: assert property (
        @(posedge clk_sys) disable iff (!i_rst_n)
        $onehot0({i_slot_rd_valid, unmapped_q})
    ) else $error("more than one read source valid in a cycle");

endmodule

//--- logic/io_hub.sv
// io_hub: CPU legacy I/O port path.
// address decoder, one register slot per device window and the
// read-return merge. reads answer two cycles after the strobe.

`timescale 1ns/1ns

module io_hub #(
    parameter int NUM_SLOTS = io_hub_pkg::MAX_SLOTS
) (
    input  logic                             clk_sys,
    input  logic                             i_rst_n,
    input  logic [io_hub_pkg::IO_ADDR_W-1:0] i_io_address,
    input  logic                             i_io_read,
    input  logic                             i_io_write,
    input  logic [io_hub_pkg::IO_DATA_W-1:0] i_io_writedata,
    output logic [io_hub_pkg::IO_DATA_W-1:0] o_io_readdata,
    output logic                             o_io_readdatavalid
);

    localparam int DATA_W = io_hub_pkg::IO_DATA_W;

    // decoder to slots.
    logic [NUM_SLOTS-1:0]              slot_rd_sel;
    logic [NUM_SLOTS-1:0]              slot_wr_sel;
    logic [io_hub_pkg::SLOT_OFS_W-1:0] reg_ofs;
    logic [DATA_W-1:0]                 wr_data;
    logic                              unmapped_rd;

    // slot returns, packed flat for the merge.
    logic [NUM_SLOTS*DATA_W-1:0]       slot_rd_data;
    logic [NUM_SLOTS-1:0]              slot_rd_valid;

    io_port_decoder #(
        .NUM_SLOTS (NUM_SLOTS)
    ) u_decoder (
        .clk_sys        (clk_sys),
        .i_io_address   (i_io_address),
        .i_io_read      (i_io_read),
        .i_io_write     (i_io_write),
        .i_io_writedata (i_io_writedata),
        .o_slot_rd_sel  (slot_rd_sel),
        .o_slot_wr_sel  (slot_wr_sel),
        .o_reg_ofs      (reg_ofs),
        .o_wr_data      (wr_data),
        .o_unmapped_rd  (unmapped_rd)
    );

    // one slot per window of the table, in table order.
    for (genvar k = 0; k < NUM_SLOTS; k++) begin : g_slot
        io_reg_slot u_slot (
            .clk_sys    (clk_sys),
            .i_rst_n    (i_rst_n),
            .i_rd_sel   (slot_rd_sel[k]),
            .i_wr_sel   (slot_wr_sel[k]),
            .i_reg_ofs  (reg_ofs),
            .i_wr_data  (wr_data),
            .o_rd_data  (slot_rd_data[k*DATA_W +: DATA_W]),
            .o_rd_valid (slot_rd_valid[k])
        );
    end

    io_read_merge #(
        .NUM_SLOTS (NUM_SLOTS)
    ) u_merge (
        .clk_sys            (clk_sys),
        .i_rst_n            (i_rst_n),
        .i_slot_rd_data     (slot_rd_data),
        .i_slot_rd_valid    (slot_rd_valid),
        .i_unmapped_rd      (unmapped_rd),
        .o_io_readdata      (o_io_readdata),
        .o_io_readdatavalid (o_io_readdatavalid)
    );

endmodule

//--- testbench/io_hub_vectors.svh
// stimulus and expected-value table for the I/O hub testbench.
// the columns are operation, value source, port address, write data and expected read byte.
// a VAL_GEN write takes a random byte and a VAL_GEN read expects the shadow value.

// every window and offset reads zero after reset.
for (int w = 0; w < NUM_WINDOWS; w++) begin
    for (int o = 0; o < 4; o++) begin
        add_row(OP_RD, VAL_TABLE, WINDOW_BASE[w] + 16'(o), 8'h00, 8'h00);
    end
end

// write window 0 first and check that the others still read zero.
for (int o = 0; o < 4; o++) begin
    add_row(OP_WR, VAL_TABLE, 16'h0020 + 16'(o), 8'(8'h10 + o), 8'h00);
end
add_row(OP_RD, VAL_TABLE, 16'h0040, 8'h00, 8'h00);
add_row(OP_RD, VAL_TABLE, 16'h03C3, 8'h00, 8'h00);
add_row(OP_RD, VAL_TABLE, 16'h0021, 8'h00, 8'h11);

// pattern of window and offset in the remaining windows.
for (int w = 1; w < NUM_WINDOWS; w++) begin
    for (int o = 0; o < 4; o++) begin
        add_row(OP_WR, VAL_TABLE, WINDOW_BASE[w] + 16'(o), 8'(16 * (w + 1) + o), 8'h00);
    end
end
for (int w = 0; w < NUM_WINDOWS; w++) begin
    for (int o = 0; o < 4; o++) begin
        add_row(OP_RD, VAL_TABLE, WINDOW_BASE[w] + 16'(o), 8'h00, 8'(16 * (w + 1) + o));
    end
end

// unmapped ports read as an empty bus and ignore writes.
add_row(OP_RD, VAL_TABLE, 16'h0080, 8'h00, 8'hFF);
add_row(OP_RD, VAL_TABLE, 16'h0300, 8'h00, 8'hFF);
add_row(OP_WR, VAL_TABLE, 16'h0024, 8'h5A, 8'h00);
add_row(OP_WR, VAL_TABLE, 16'h0300, 8'hA5, 8'h00);
add_row(OP_RD, VAL_TABLE, 16'h0024, 8'h00, 8'hFF);
add_row(OP_RD, VAL_TABLE, 16'h0020, 8'h00, 8'h10);
add_row(OP_RD, VAL_TABLE, 16'h0300, 8'h00, 8'hFF);
add_row(OP_IDLE, VAL_TABLE, 16'h0000, 8'h00, 8'h00);

// back-to-back reads mixing slots and unmapped ports.
add_row(OP_RD, VAL_TABLE, 16'h0042, 8'h00, 8'h22);
add_row(OP_RD, VAL_TABLE, 16'h0080, 8'h00, 8'hFF);
add_row(OP_RD, VAL_TABLE, 16'h03C1, 8'h00, 8'h61);
add_row(OP_RD, VAL_TABLE, 16'h0073, 8'h00, 8'h43);
add_row(OP_RD, VAL_TABLE, 16'hFFFF, 8'h00, 8'hFF);
add_row(OP_RD, VAL_TABLE, 16'h00A0, 8'h00, 8'h50);
add_row(OP_RD, VAL_TABLE, 16'h0062, 8'h00, 8'h32);

// random write and an immediate read of the same register.
for (int w = 0; w < NUM_WINDOWS; w++) begin
    add_row(OP_WR, VAL_GEN, WINDOW_BASE[w] + 16'(w % 4), 8'h00, 8'h00);
    add_row(OP_RD, VAL_GEN, WINDOW_BASE[w] + 16'(w % 4), 8'h00, 8'h00);
end
add_row(OP_RD, VAL_GEN, 16'h0020, 8'h00, 8'h00);
add_row(OP_RD, VAL_GEN, 16'h0021, 8'h00, 8'h00);
add_row(OP_IDLE, VAL_TABLE, 16'h0000, 8'h00, 8'h00);

//--- testbench/io_hub_tb.sv
// io_hub_tb: testbench for the legacy I/O hub.
// clock, reset, table-driven stimulus with a shadow register model,
// read-return checking and a cycle timeout.

`timescale 1ns/1ns

module io_hub_tb;

    localparam int OP_IDLE     = 0;
    localparam int OP_RD       = 1;
    localparam int OP_WR       = 2;
    localparam bit VAL_TABLE   = 1'b0;
    localparam bit VAL_GEN     = 1'b1;
    localparam int NUM_WINDOWS = 6;
    localparam logic [15:0] WINDOW_BASE [NUM_WINDOWS] = '{
        16'h0020, 16'h0040, 16'h0060, 16'h0070, 16'h00A0, 16'h03C0
    };

    logic                             clk_sys;
    logic                             i_rst_n;
    logic [io_hub_pkg::IO_ADDR_W-1:0] i_io_address;
    logic                             i_io_read;
    logic                             i_io_write;
    logic [io_hub_pkg::IO_DATA_W-1:0] i_io_writedata;
    logic [io_hub_pkg::IO_DATA_W-1:0] o_io_readdata;
    logic                             o_io_readdatavalid;

    // stimulus table, one entry per cycle.
    int          row_op [$];
    bit          row_gen [$];
    logic [15:0] row_addr [$];
    logic [7:0]  row_data [$];
    logic [7:0]  row_exp [$];

    // reads in flight.
    logic [7:0]  pend_exp [$];
    int          pend_due [$];

    logic [7:0]  shadow [NUM_WINDOWS][4];
    int          seed;
    int          cycle_cnt;
    int          cycle_limit;

    io_hub dut0 (
        .clk_sys            (clk_sys),
        .i_rst_n            (i_rst_n),
        .i_io_address       (i_io_address),
        .i_io_read          (i_io_read),
        .i_io_write         (i_io_write),
        .i_io_writedata     (i_io_writedata),
        .o_io_readdata      (o_io_readdata),
        .o_io_readdatavalid (o_io_readdatavalid)
    );

    always #20 clk_sys = ~clk_sys;

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic add_row(input int op, input bit gen, input logic [15:0] addr,
                           input logic [7:0] data, input logic [7:0] exp_byte);
        row_op.push_back(op);
        row_gen.push_back(gen);
        row_addr.push_back(addr);
        row_data.push_back(data);
        row_exp.push_back(exp_byte);
    endtask

    task automatic load_vectors();
        `include "io_hub_vectors.svh"
    endtask

    // index of the window holding a port, or -1 when unmapped.
    function automatic int window_of(input logic [15:0] addr);
        int found;
        found = -1;
        for (int w = 0; w < NUM_WINDOWS; w++) begin
            if (addr[15:2] == WINDOW_BASE[w][15:2]) begin
                found = w;
            end
        end
        return found;
    endfunction

    // compares the read return seen in cycle c with the oldest pending read.
    task automatic check_return(input int c);
        if (o_io_readdatavalid) begin
            assert (pend_exp.size() > 0)
            else report_failure("read data valid arrived with no read pending");
            assert (pend_due[0] == c)
            else report_failure($sformatf("read valid came in cycle %0d instead of cycle %0d",
                                          c, pend_due[0]));
            assert (o_io_readdata == pend_exp[0])
            else report_failure($sformatf("** Error: o_io_readdata = 0x%02h, expected 0x%02h",
                                          o_io_readdata, pend_exp[0]));
            void'(pend_exp.pop_front());
            void'(pend_due.pop_front());
        end else if (pend_due.size() > 0) begin
            assert (pend_due[0] > c)
            else report_failure("read valid did not arrive two cycles after the read");
        end
    endtask

    // timeout.
    always @(posedge clk_sys) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            report_failure($sformatf("timeout after %0d cycles", cycle_cnt));
        end
    end

    initial begin
        int         cycle;
        int         w;
        int         rnd;
        logic [7:0] wdata;
        logic [7:0] exp_byte;
        clk_sys        = 1'b0;
        i_rst_n        = 1'b0;
        i_io_address   = '0;
        i_io_read      = 1'b0;
        i_io_write     = 1'b0;
        i_io_writedata = '0;
        seed           = 91;
        cycle_cnt      = 0;
        for (int k = 0; k < NUM_WINDOWS; k++) begin
            for (int o = 0; o < 4; o++) begin
                shadow[k][o] = 8'h00;
            end
        end
        load_vectors();
        cycle_limit = 10 + 4 * row_op.size() + 20;
        repeat (10) @(negedge clk_sys);
        i_rst_n = 1'b1;
        assert (o_io_readdatavalid == 1'b0)
        else report_failure($sformatf("** Error: o_io_readdatavalid = 0x%h after reset, expected 0x0",
                                      o_io_readdatavalid));
        assert (o_io_readdata == 8'h00)
        else report_failure($sformatf("** Error: o_io_readdata = 0x%02h after reset, expected 0x00",
                                      o_io_readdata));
        cycle = 0;
        for (int row = 0; row < row_op.size(); row++) begin
            check_return(cycle);
            w = window_of(row_addr[row]);
            rnd = $random(seed);
            wdata = (row_gen[row] == VAL_GEN) ? rnd[7:0] : row_data[row];
            i_io_address   = row_addr[row];
            i_io_read      = (row_op[row] == OP_RD);
            i_io_write     = (row_op[row] == OP_WR);
            i_io_writedata = wdata;
            if (row_op[row] == OP_WR && w >= 0) begin
                shadow[w][row_addr[row][1:0]] = wdata;
            end
            if (row_op[row] == OP_RD) begin
                if (row_gen[row] == VAL_TABLE) begin
                    exp_byte = row_exp[row];
                end else if (w >= 0) begin
                    exp_byte = shadow[w][row_addr[row][1:0]];
                end else begin
                    exp_byte = 8'hFF;
                end
                pend_exp.push_back(exp_byte);
                pend_due.push_back(cycle + 2);
            end
            @(negedge clk_sys);
            cycle = cycle + 1;
        end
        i_io_read  = 1'b0;
        i_io_write = 1'b0;
        // drain the pipeline, then make sure no stray valid follows.
        while (pend_exp.size() > 0) begin
            check_return(cycle);
            @(negedge clk_sys);
            cycle = cycle + 1;
        end
        repeat (3) begin
            check_return(cycle);
            @(negedge clk_sys);
            cycle = cycle + 1;
        end
        $display("All tests passed");
        $finish;
    end

endmodule

//--- io_hub.f
+incdir+testbench
logic/io_hub_pkg.sv
logic/io_port_decoder.sv
logic/io_reg_slot.sv
logic/io_read_merge.sv
logic/io_hub.sv
testbench/io_hub_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the I/O hub testbench with Verilator and runs it.
# The run counts as failed if the log holds the testbench's fail line
# or if any command returns a failing status.

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_TEXT="Some tests failed"

if ! verilator --binary --timing --assert \
        --top-module io_hub_tb \
        -f io_hub.f \
        --Mdir obj_dir \
        -o io_hub_sim; then
    echo "build failed"
    exit 1
fi

./obj_dir/io_hub_sim > "$LOG" 2>&1
sim_status=$?

cat "$LOG"

if grep -q "$FAIL_TEXT" "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

echo "simulation finished without failures"
exit 0
